// ==== hdl/bell_game_top.sv ====
`timescale 1ns/10ps

module bell_game_top #(
    parameter int score_w = 8,
    parameter int start_points = 20,
    parameter int tick_cycles = 4,
    parameter int win_margin = 9
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         card_valid,
    input  logic [bell_pkg::color_w-1:0] card_c1,
    input  logic [bell_pkg::color_w-1:0] card_c2,
    input  logic [bell_pkg::num_w-1:0]   card_n1,
    input  logic [bell_pkg::num_w-1:0]   card_n2,
    input  logic [bell_pkg::key_w-1:0]   keypad_in,
    output logic [score_w-1:0]           score_a,
    output logic [score_w-1:0]           score_b,
    output logic [1:0]                   winner_led,
    output logic                         round_done
);
    import bell_pkg::*;

    logic [color_w-1:0] held_c1;
    logic [color_w-1:0] held_c2;
    logic [num_w-1:0]   held_n1;
    logic [num_w-1:0]   held_n2;
    logic               bell_right;
    logic               timer_start;
    logic [score_w-1:0] points;
    logic               credit_a;
    logic               debit_a;
    logic               credit_b;
    logic               debit_b;
    logic [score_w-1:0] credit_amount;
    logic               game_over;

    round_fsm #(
        .score_w(score_w)
    ) i_round_fsm (
        .clk(clk),
        .rst(rst),
        .card_valid(card_valid),
        .card_c1(card_c1),
        .card_c2(card_c2),
        .card_n1(card_n1),
        .card_n2(card_n2),
        .keypad_in(keypad_in),
        .bell_right(bell_right),
        .points(points),
        .game_over(game_over),
        .held_c1(held_c1),
        .held_c2(held_c2),
        .held_n1(held_n1),
        .held_n2(held_n2),
        .timer_start(timer_start),
        .credit_a(credit_a),
        .debit_a(debit_a),
        .credit_b(credit_b),
        .debit_b(debit_b),
        .credit_amount(credit_amount),
        .round_done(round_done)
    );

    reaction_timer #(
        .score_w(score_w),
        .start_points(start_points),
        .tick_cycles(tick_cycles)
    ) i_reaction_timer (
        .clk(clk),
        .rst(rst),
        .timer_start(timer_start),
        .points(points)
    );

    ring_judge i_ring_judge (
        .card_c1(held_c1),
        .card_c2(held_c2),
        .card_n1(held_n1),
        .card_n2(held_n2),
        .bell_right(bell_right)
    );

    // one bank per player on a shared amount bus
    score_bank #(
        .score_w(score_w)
    ) i_bank_a (
        .clk(clk),
        .rst(rst),
        .credit(credit_a),
        .debit(debit_a),
        .amount(credit_amount),
        .score(score_a)
    );

    score_bank #(
        .score_w(score_w)
    ) i_bank_b (
        .clk(clk),
        .rst(rst),
        .credit(credit_b),
        .debit(debit_b),
        .amount(credit_amount),
        .score(score_b)
    );

    win_detect #(
        .score_w(score_w),
        .win_margin(win_margin)
    ) i_win_detect (
        .clk(clk),
        .rst(rst),
        .score_a(score_a),
        .score_b(score_b),
        .winner_led(winner_led),
        .game_over(game_over)
    );

endmodule

// ==== hdl/bell_pkg.sv ====
package bell_pkg;

    // keypad
    localparam int key_w = 4;

    // player keys on the 4x4 pad
    localparam logic [key_w-1:0] key_a = 4'd7;
    localparam logic [key_w-1:0] key_b = 4'd9;

    // card fields
    localparam int color_w = 2;
    localparam int num_w = 3;

    // the number the whole rule turns on
    localparam logic [num_w-1:0] bell_num = 3'd5;

    // winner led codes
    localparam int led_w = 2;

    localparam logic [led_w-1:0] led_none = 2'b00;
    localparam logic [led_w-1:0] led_a = 2'b01;
    localparam logic [led_w-1:0] led_b = 2'b10;

endpackage

// ==== hdl/reaction_timer.sv ====
`timescale 1ns/10ps

module reaction_timer #(
    parameter int score_w = 8,
    parameter int start_points = 20,
    parameter int tick_cycles = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               timer_start,
    output logic [score_w-1:0] points
);

    localparam int pre_w = $clog2(tick_cycles + 1);
    localparam logic [pre_w-1:0] pre_last = pre_w'(tick_cycles - 1);
    localparam logic [score_w-1:0] points_init = score_w'(start_points);
    localparam logic [score_w-1:0] points_floor = score_w'(1);

    logic [pre_w-1:0] prescale;

    always_ff @(posedge clk) begin
        if (!rst) begin
            prescale <= '0;
            points <= points_init;
        end else if (timer_start) begin
            // reveal restarts the countdown from the top
            prescale <= '0;
            points <= points_init;
        end else if (prescale == pre_last) begin
            prescale <= '0;
            if (points > points_floor) begin
                points <= points - 1'b1;
            end
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

    // a right press always earns something
    a_points_nonzero: assert property (
        @(posedge clk) disable iff (!rst) points != '0
    ) else $error("reaction_timer: points dropped to zero");

endmodule

// ==== hdl/ring_judge.sv ====
`timescale 1ns/10ps

module ring_judge (
    input  logic [bell_pkg::color_w-1:0] card_c1,
    input  logic [bell_pkg::color_w-1:0] card_c2,
    input  logic [bell_pkg::num_w-1:0]   card_n1,
    input  logic [bell_pkg::num_w-1:0]   card_n2,
    output logic                         bell_right
);
    import bell_pkg::*;

    // one extra bit so 6 + 7 cannot wrap back onto five
    logic [num_w:0] num_sum;
    logic           same_color;
    logic           sum_hit;
    logic           five_shown;

    assign num_sum = {1'b0, card_n1} + {1'b0, card_n2};
    assign same_color = (card_c1 == card_c2);
    assign sum_hit = (num_sum == {1'b0, bell_num});

    // either card shows a five
    assign five_shown = (card_n1 == bell_num) || (card_n2 == bell_num);

    always_comb begin
        if (same_color) begin
            bell_right = sum_hit;
        end else begin
            bell_right = five_shown;
        end
    end

endmodule

// ==== hdl/round_fsm.sv ====
`timescale 1ns/10ps

module round_fsm #(
    parameter int score_w = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         card_valid,
    input  logic [bell_pkg::color_w-1:0] card_c1,
    input  logic [bell_pkg::color_w-1:0] card_c2,
    input  logic [bell_pkg::num_w-1:0]   card_n1,
    input  logic [bell_pkg::num_w-1:0]   card_n2,
    input  logic [bell_pkg::key_w-1:0]   keypad_in,
    input  logic                         bell_right,
    input  logic [score_w-1:0]           points,
    input  logic                         game_over,
    output logic [bell_pkg::color_w-1:0] held_c1,
    output logic [bell_pkg::color_w-1:0] held_c2,
    output logic [bell_pkg::num_w-1:0]   held_n1,
    output logic [bell_pkg::num_w-1:0]   held_n2,
    output logic                         timer_start,
    output logic                         credit_a,
    output logic                         debit_a,
    output logic                         credit_b,
    output logic                         debit_b,
    output logic [score_w-1:0]           credit_amount,
    output logic                         round_done
);
    import bell_pkg::*;

    typedef enum logic [1:0] {idle, open, closed} state_t;

    state_t state;
    logic   new_round;
    logic   press_a;
    logic   press_b;
    logic   accept;

    // no new rounds after a winner
    assign new_round = card_valid && !game_over;
    assign timer_start = new_round;

    assign press_a = (keypad_in == key_a);
    assign press_b = (keypad_in == key_b);

    // fresh cards win over a press in the same cycle
    assign accept = (state == open) && !new_round && !game_over && (press_a || press_b);

    always_ff @(posedge clk) begin
        if (new_round) begin
            held_c1 <= card_c1;
            held_c2 <= card_c2;
            held_n1 <= card_n1;
            held_n2 <= card_n2;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= idle;
        end else if (game_over) begin
            state <= idle;
        end else if (new_round) begin
            state <= open;
        end else if (accept) begin
            state <= closed;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            credit_a <= 1'b0;
            debit_a <= 1'b0;
            credit_b <= 1'b0;
            debit_b <= 1'b0;
            round_done <= 1'b0;
        end else begin
            credit_a <= 1'b0;
            debit_a <= 1'b0;
            credit_b <= 1'b0;
            debit_b <= 1'b0;
            round_done <= accept;
            if (accept && bell_right) begin
                credit_a <= press_a;
                credit_b <= press_b;
            end else if (accept) begin
                // on a wrong press the other player gets the point
                debit_a <= press_a;
                debit_b <= press_b;
                credit_a <= press_b;
                credit_b <= press_a;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            credit_amount <= bell_right ? points : score_w'(1);
        end
    end

    a_no_credit_and_debit: assert property (
        @(posedge clk) disable iff (!rst) !(credit_a && debit_a) && !(credit_b && debit_b)
    ) else $error("round_fsm: credit and debit to the same player");

    a_done_has_strobe: assert property (
        @(posedge clk) disable iff (!rst)
        round_done |-> (credit_a || credit_b || debit_a || debit_b)
    ) else $error("round_fsm: round_done without a score strobe");

endmodule

// ==== hdl/score_bank.sv ====
`timescale 1ns/10ps

module score_bank #(
    parameter int score_w = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               credit,
    input  logic               debit,
    input  logic [score_w-1:0] amount,
    output logic [score_w-1:0] score
);

    logic [score_w:0]   add_full;
    logic [score_w-1:0] add_sat;
    logic [score_w-1:0] sub_sat;

    // carry out means the sum ran past the top
    assign add_full = {1'b0, score} + {1'b0, amount};
    assign add_sat = add_full[score_w] ? '1 : add_full[score_w-1:0];

    // stays at zero instead of wrapping
    assign sub_sat = (score == '0) ? '0 : score - 1'b1;

    always_ff @(posedge clk) begin
        if (!rst) begin
            score <= '0;
        end else if (credit) begin
            score <= add_sat;
        end else if (debit) begin
            score <= sub_sat;
        end
    end

    // the round logic never asks for both at once
    a_single_update: assert property (
        @(posedge clk) disable iff (!rst) !(credit && debit)
    ) else $error("score_bank: credit and debit together");

endmodule

// ==== hdl/win_detect.sv ====
`timescale 1ns/10ps

module win_detect #(
    parameter int score_w = 8,
    parameter int win_margin = 9
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [score_w-1:0] score_a,
    input  logic [score_w-1:0] score_b,
    output logic [1:0]         winner_led,
    output logic               game_over
);
    import bell_pkg::*;

    localparam logic [score_w:0] margin = (score_w + 1)'(win_margin);

    logic [score_w:0] a_wide;
    logic [score_w:0] b_wide;

    assign a_wide = {1'b0, score_a};
    assign b_wide = {1'b0, score_b};

    always_ff @(posedge clk) begin
        if (!rst) begin
            winner_led <= led_none;
            game_over <= 1'b0;
        end else if (!game_over) begin
            // led freezes once somebody has won
            if (a_wide > b_wide + margin) begin
                winner_led <= led_a;
                game_over <= 1'b1;
            end else if (b_wide > a_wide + margin) begin
                winner_led <= led_b;
                game_over <= 1'b1;
            end else begin
                winner_led <= led_none;
            end
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build the bell game testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_bell_game \
    -f vlog.f \
    -o tb_bell_game
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_bell_game)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
echo "pass message not found"
exit 1

// ==== sim/tb_bell_game.sv ====
`timescale 1ns/10ps

module tb_bell_game;
    import bell_pkg::*;

    // model copies of the default top level parameters
    localparam int score_w = 8;
    localparam int start_points = 20;
    localparam int tick_cycles = 4;
    localparam int win_margin = 9;
    localparam int score_max = 255;
    localparam int done_timeout = 20;

    logic               clk;
    logic               rst;
    logic               card_valid;
    logic [color_w-1:0] card_c1;
    logic [color_w-1:0] card_c2;
    logic [num_w-1:0]   card_n1;
    logic [num_w-1:0]   card_n2;
    logic [key_w-1:0]   keypad_in;
    logic [score_w-1:0] score_a;
    logic [score_w-1:0] score_b;
    logic [1:0]         winner_led;
    logic               round_done;

    // reference model state
    int                 model_a;
    int                 model_b;
    bit                 model_over;
    bit                 round_open;
    int                 held_c1;
    int                 held_c2;
    int                 held_n1;
    int                 held_n2;
    logic [score_w-1:0] exp_a;
    logic [score_w-1:0] exp_b;
    logic [1:0]         exp_led;
    logic               exp_done;
    logic [15:0]        lfsr;
    int                 value_errors;
    int                 timeout_errors;

    bell_game_top i_dut (
        .clk(clk),
        .rst(rst),
        .card_valid(card_valid),
        .card_c1(card_c1),
        .card_c2(card_c2),
        .card_n1(card_n1),
        .card_n2(card_n2),
        .keypad_in(keypad_in),
        .score_a(score_a),
        .score_b(score_b),
        .winner_led(winner_led),
        .round_done(round_done)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    a_score_a: assert property (@(posedge clk) disable iff (!rst) score_a == exp_a)
        else begin
            value_errors++;
            $display("FAILED %0t: score_a is %0d, expected %0d", $time, $sampled(score_a), exp_a);
        end

    a_score_b: assert property (@(posedge clk) disable iff (!rst) score_b == exp_b)
        else begin
            value_errors++;
            $display("FAILED %0t: score_b is %0d, expected %0d", $time, $sampled(score_b), exp_b);
        end

    a_led: assert property (@(posedge clk) disable iff (!rst) winner_led == exp_led)
        else begin
            value_errors++;
            $display("FAILED %0t: winner_led is %b, expected %b", $time,
                $sampled(winner_led), exp_led);
        end

    a_done: assert property (@(posedge clk) disable iff (!rst) round_done == exp_done)
        else begin
            value_errors++;
            $display("FAILED %0t: round_done is %b, expected %b", $time,
                $sampled(round_done), exp_done);
        end

    // 16 bit fibonacci with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic draw_bits(input int n, output int val);
        int i;
        val = 0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val = (val << 1) | int'(lfsr[0]);
        end
    endtask

    // same colour wants a sum of five and different colours want a five shown
    function automatic bit expected_right(input int c1, input int c2, input int n1, input int n2);
        if (c1 == c2) begin
            return (n1 + n2) == 5;
        end
        return (n1 == 5) || (n2 == 5);
    endfunction

    function automatic int expected_points(input int delay);
        int p;
        p = start_points - (delay - 1) / tick_cycles;
        return (p < 1) ? 1 : p;
    endfunction

    function automatic int add_clip(input int s, input int amt);
        return (s + amt > score_max) ? score_max : s + amt;
    endfunction

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic deal(input int c1, input int c2, input int n1, input int n2);
        card_valid = 1'b1;
        card_c1 = color_w'(c1);
        card_c2 = color_w'(c2);
        card_n1 = num_w'(n1);
        card_n2 = num_w'(n2);
        if (!model_over) begin
            held_c1 = c1;
            held_c2 = c2;
            held_n1 = n1;
            held_n2 = n2;
            round_open = 1'b1;
        end
        @(negedge clk);
        card_valid = 1'b0;
    endtask

    // noise code is held on the pad until the real press
    task automatic press_after(input logic [key_w-1:0] key, input int delay,
                               input logic [key_w-1:0] noise);
        int na;
        int nb;
        int cnt;
        bit accepted;
        keypad_in = noise;
        repeat (delay - 1) @(negedge clk);
        accepted = round_open && !model_over && (key == key_a || key == key_b);
        keypad_in = key;
        @(negedge clk);
        keypad_in = '0;
        if (!accepted) begin
            idle(3);
        end else begin
            exp_done = 1'b1;
            cnt = 0;
            while (!round_done && cnt < done_timeout) begin
                @(negedge clk);
                cnt++;
            end
            if (!round_done) begin
                timeout_errors++;
                $display("timeout at %0t: no round_done after an accepted press", $time);
            end
            na = model_a;
            nb = model_b;
            if (expected_right(held_c1, held_c2, held_n1, held_n2)) begin
                if (key == key_a) begin
                    na = add_clip(na, expected_points(delay));
                end else begin
                    nb = add_clip(nb, expected_points(delay));
                end
            end else if (key == key_a) begin
                na = (na > 0) ? na - 1 : 0;
                nb = add_clip(nb, 1);
            end else begin
                nb = (nb > 0) ? nb - 1 : 0;
                na = add_clip(na, 1);
            end
            round_open = 1'b0;
            @(negedge clk);
            exp_done = 1'b0;
            model_a = na;
            model_b = nb;
            exp_a = score_w'(na);
            exp_b = score_w'(nb);
            // led follows the new scores one cycle later
            @(negedge clk);
            if (model_a > model_b + win_margin) begin
                exp_led = led_a;
                model_over = 1'b1;
            end else if (model_b > model_a + win_margin) begin
                exp_led = led_b;
                model_over = 1'b1;
            end
        end
    endtask

    initial begin
        int r;
        int c1;
        int c2;
        int n1;
        int n2;
        int who;
        int delay;
        rst = 1'b0;
        card_valid = 1'b0;
        card_c1 = '0;
        card_c2 = '0;
        card_n1 = '0;
        card_n2 = '0;
        keypad_in = '0;
        model_a = 0;
        model_b = 0;
        model_over = 1'b0;
        round_open = 1'b0;
        exp_a = '0;
        exp_b = '0;
        exp_led = led_none;
        exp_done = 1'b0;
        lfsr = 16'd69;
        value_errors = 0;
        timeout_errors = 0;
        idle(4);
        rst = 1'b1;
        idle(3);

        // no round open yet
        press_after(key_a, 1, 4'h0);
        // 7 + 6 must not wrap onto five
        deal(1, 1, 7, 6);
        press_after(key_a, 2, 4'h0);
        deal(1, 2, 4, 5);
        press_after(key_b, 70, 4'h3);
        deal(3, 3, 4, 1);
        press_after(key_a, 60, 4'h0);
        // second press into a closed round
        press_after(key_b, 1, 4'h0);
        // long enough to sit on the floor
        deal(0, 2, 5, 7);
        press_after(key_b, 90, 4'h3);
        // redeal swaps a right hand for a wrong one
        deal(0, 0, 2, 3);
        idle(12);
        deal(2, 1, 1, 2);
        press_after(key_a, 2, 4'h0);
        deal(2, 2, 0, 5);
        press_after(key_b, 53, 4'h0);
        // points restart on the redeal
        deal(1, 3, 6, 2);
        idle(30);
        deal(2, 0, 5, 5);
        press_after(key_a, 13, 4'h0);

        for (r = 0; r < 12; r++) begin
            draw_bits(2, c1);
            draw_bits(2, c2);
            draw_bits(3, n1);
            draw_bits(3, n2);
            draw_bits(1, who);
            draw_bits(5, delay);
            deal(c1, c2, n1, n2);
            press_after((who != 0) ? key_b : key_a, delay + 1, 4'h0);
        end

        // leader keeps scoring until somebody wins
        r = 0;
        while (!model_over && r < 20) begin
            deal(1, 1, 3, 2);
            press_after((model_a >= model_b) ? key_a : key_b, 1, 4'h0);
            r++;
        end

        // everything below is ignored after game over
        deal(0, 0, 2, 3);
        press_after(key_a, 1, 4'h0);
        deal(1, 2, 5, 0);
        press_after(key_b, 3, 4'h0);
        idle(4);

        $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hdl/bell_pkg.sv
hdl/ring_judge.sv
hdl/reaction_timer.sv
hdl/round_fsm.sv
hdl/score_bank.sv
hdl/win_detect.sv
hdl/bell_game_top.sv
sim/tb_bell_game.sv
